/* build.f */
+incdir+common
common/rv_pkg.sv
hdl/ext_cfg.sv
decoder/decoder.sv
hdl/regfile.sv
alu/alu.sv
hdl/rv_exec_top.sv
bench/tb_rv_exec.sv

/* run.sh */
#!/usr/bin/env bash
# Builds the execute slice testbench with Verilator and runs it.
cd "$(dirname "$0")" || exit 1
log=sim.log

verilator --binary --timing --assert -Wno-fatal -f build.f --top-module tb_rv_exec -o sim_tb
if [ $? -ne 0 ]; then
  echo "Verilator build failed"
  exit 1
fi

./obj_dir/sim_tb > "$log" 2>&1
status=$?
cat "$log"
if [ $status -ne 0 ]; then
  echo "Simulator exited with status $status"
  exit 1
fi

if grep -q "SIMULATION FAILED" "$log"; then
  exit 1
fi
exit 0

/* bench/tb_rv_exec.sv */
`timescale 1ns/1ps
`default_nettype none

module tb_rv_exec;

  // ************************************************************
  // Instruction table for the reference model
  // ************************************************************

  typedef enum int {
    op_add, op_sub, op_sll, op_slt, op_sltu, op_xor, op_srl, op_sra, op_or, op_and,
    op_addi, op_slti, op_sltiu, op_xori, op_ori, op_andi, op_slli, op_srli, op_srai,
    op_lui, op_auipc, op_sh1add, op_sh2add, op_sh3add,
    op_andn, op_orn, op_xnor, op_min, op_minu, op_max, op_maxu, op_rol, op_ror, op_rori,
    op_zexth, op_clz, op_ctz, op_cpop, op_sextb, op_sexth, op_rev8, op_orcb,
    op_bclr, op_bset, op_binv, op_bext, op_bclri, op_bseti, op_binvi, op_bexti,
    op_count
  } op_e;

  localparam int n_ops = int'(op_count);
  localparam int rounds = 4;
  // Each random op costs five instructions: two register loads and the op itself.
  localparam int instr_budget = (rounds + 6) * n_ops * 5 + 200;
  localparam int timeout_cycles = instr_budget + 10 + 100;

  localparam logic [2:0] ext_none = 3'b000;
  localparam logic [2:0] ext_zba = 3'b001;
  localparam logic [2:0] ext_zbb = 3'b010;
  localparam logic [2:0] ext_zbs = 3'b100;
  localparam logic [2:0] fmt_r = 3'd0;   // Register form.
  localparam logic [2:0] fmt_i = 3'd1;   // 12-bit immediate.
  localparam logic [2:0] fmt_sh = 3'd2;  // Shift amount or bit index.
  localparam logic [2:0] fmt_un = 3'd3;  // Unary, fixed rs2 field, OP-IMM.
  localparam logic [2:0] fmt_ur = 3'd4;  // Unary, fixed rs2 field, OP.
  localparam logic [2:0] fmt_u = 3'd5;   // Upper immediate, funct7 field holds the opcode.

  logic        clk;
  logic        rst;
  logic        instr_valid;
  logic [31:0] instr;
  logic        cfg_wr;
  logic [2:0]  cfg_data;
  logic        wb_valid;
  logic [4:0]  wb_addr;
  logic [31:0] wb_data;
  logic        illegal;

  logic [31:0] shadow [0:31];
  logic [2:0]  ext_model;
  logic        exp_wb_n = 1'b0;
  logic        exp_ill_n = 1'b0;
  logic [4:0]  exp_addr_n = '0;
  logic [31:0] exp_data_n = '0;
  logic        exp_wb_q = 1'b0;
  logic        exp_ill_q = 1'b0;
  logic [4:0]  exp_addr_q = '0;
  logic [31:0] exp_data_q = '0;
  int          errors = 0;
  int          issued = 0;
  int          cycle_count = 0;

  rv_exec_top rv_exec_top_i (
    .clk         (clk),
    .rst         (rst),
    .instr_valid (instr_valid),
    .instr       (instr),
    .cfg_wr      (cfg_wr),
    .cfg_data    (cfg_data),
    .wb_valid    (wb_valid),
    .wb_addr     (wb_addr),
    .wb_data     (wb_data),
    .illegal     (illegal)
  );

  initial begin
    clk = 1'b0;
    forever #50 clk = ~clk;
  end

  // {needed extension, format, funct7, funct3, fixed rs2 field}
  function automatic logic [20:0] op_spec(op_e op);
    case (op)
      op_add:    return {ext_none, fmt_r, 7'h00, 3'd0, 5'd0};
      op_sub:    return {ext_none, fmt_r, 7'h20, 3'd0, 5'd0};
      op_sll:    return {ext_none, fmt_r, 7'h00, 3'd1, 5'd0};
      op_slt:    return {ext_none, fmt_r, 7'h00, 3'd2, 5'd0};
      op_sltu:   return {ext_none, fmt_r, 7'h00, 3'd3, 5'd0};
      op_xor:    return {ext_none, fmt_r, 7'h00, 3'd4, 5'd0};
      op_srl:    return {ext_none, fmt_r, 7'h00, 3'd5, 5'd0};
      op_sra:    return {ext_none, fmt_r, 7'h20, 3'd5, 5'd0};
      op_or:     return {ext_none, fmt_r, 7'h00, 3'd6, 5'd0};
      op_and:    return {ext_none, fmt_r, 7'h00, 3'd7, 5'd0};
      op_addi:   return {ext_none, fmt_i, 7'h00, 3'd0, 5'd0};
      op_slti:   return {ext_none, fmt_i, 7'h00, 3'd2, 5'd0};
      op_sltiu:  return {ext_none, fmt_i, 7'h00, 3'd3, 5'd0};
      op_xori:   return {ext_none, fmt_i, 7'h00, 3'd4, 5'd0};
      op_ori:    return {ext_none, fmt_i, 7'h00, 3'd6, 5'd0};
      op_andi:   return {ext_none, fmt_i, 7'h00, 3'd7, 5'd0};
      op_slli:   return {ext_none, fmt_sh, 7'h00, 3'd1, 5'd0};
      op_srli:   return {ext_none, fmt_sh, 7'h00, 3'd5, 5'd0};
      op_srai:   return {ext_none, fmt_sh, 7'h20, 3'd5, 5'd0};
      op_lui:    return {ext_none, fmt_u, 7'b0110111, 3'd0, 5'd0};
      op_auipc:  return {ext_none, fmt_u, 7'b0010111, 3'd0, 5'd0};
      op_sh1add: return {ext_zba, fmt_r, 7'h10, 3'd2, 5'd0};
      op_sh2add: return {ext_zba, fmt_r, 7'h10, 3'd4, 5'd0};
      op_sh3add: return {ext_zba, fmt_r, 7'h10, 3'd6, 5'd0};
      op_andn:   return {ext_zbb, fmt_r, 7'h20, 3'd7, 5'd0};
      op_orn:    return {ext_zbb, fmt_r, 7'h20, 3'd6, 5'd0};
      op_xnor:   return {ext_zbb, fmt_r, 7'h20, 3'd4, 5'd0};
      op_min:    return {ext_zbb, fmt_r, 7'h05, 3'd4, 5'd0};
      op_minu:   return {ext_zbb, fmt_r, 7'h05, 3'd5, 5'd0};
      op_max:    return {ext_zbb, fmt_r, 7'h05, 3'd6, 5'd0};
      op_maxu:   return {ext_zbb, fmt_r, 7'h05, 3'd7, 5'd0};
      op_rol:    return {ext_zbb, fmt_r, 7'h30, 3'd1, 5'd0};
      op_ror:    return {ext_zbb, fmt_r, 7'h30, 3'd5, 5'd0};
      op_rori:   return {ext_zbb, fmt_sh, 7'h30, 3'd5, 5'd0};
      op_zexth:  return {ext_zbb, fmt_ur, 7'h04, 3'd4, 5'd0};
      op_clz:    return {ext_zbb, fmt_un, 7'h30, 3'd1, 5'd0};
      op_ctz:    return {ext_zbb, fmt_un, 7'h30, 3'd1, 5'd1};
      op_cpop:   return {ext_zbb, fmt_un, 7'h30, 3'd1, 5'd2};
      op_sextb:  return {ext_zbb, fmt_un, 7'h30, 3'd1, 5'd4};
      op_sexth:  return {ext_zbb, fmt_un, 7'h30, 3'd1, 5'd5};
      op_rev8:   return {ext_zbb, fmt_un, 7'h34, 3'd5, 5'd24};
      op_orcb:   return {ext_zbb, fmt_un, 7'h14, 3'd5, 5'd7};
      op_bclr:   return {ext_zbs, fmt_r, 7'h24, 3'd1, 5'd0};
      op_bset:   return {ext_zbs, fmt_r, 7'h14, 3'd1, 5'd0};
      op_binv:   return {ext_zbs, fmt_r, 7'h34, 3'd1, 5'd0};
      op_bext:   return {ext_zbs, fmt_r, 7'h24, 3'd5, 5'd0};
      op_bclri:  return {ext_zbs, fmt_sh, 7'h24, 3'd1, 5'd0};
      op_bseti:  return {ext_zbs, fmt_sh, 7'h14, 3'd1, 5'd0};
      op_binvi:  return {ext_zbs, fmt_sh, 7'h34, 3'd1, 5'd0};
      default:   return {ext_zbs, fmt_sh, 7'h24, 3'd5, 5'd0};
    endcase
  endfunction

  // Result of each instruction as the ISA defines it.
  function automatic logic [31:0] compute(op_e op, logic [31:0] a, logic [31:0] b);
    logic [4:0]  s;
    logic [31:0] r;
    logic [31:0] t;
    int          n;
    s = b[4:0];
    r = '0;
    t = a;
    n = 0;
    case (op)
      op_add, op_addi:             r = a + b;
      op_sub:                      r = a - b;
      op_sll, op_slli:             r = a << s;
      op_srl, op_srli:             r = a >> s;
      op_sra, op_srai:             r = $signed(a) >>> s;
      op_slt, op_slti:             r = {31'b0, $signed(a) < $signed(b)};
      op_sltu, op_sltiu:           r = {31'b0, a < b};
      op_xor, op_xori:             r = a ^ b;
      op_or, op_ori:               r = a | b;
      op_and, op_andi:             r = a & b;
      op_lui, op_auipc:            r = b;  // The PC is zero.
      op_sh1add:                   r = b + {a[30:0], 1'b0};
      op_sh2add:                   r = b + {a[29:0], 2'b0};
      op_sh3add:                   r = b + {a[28:0], 3'b0};
      op_andn:                     r = a & ~b;
      op_orn:                      r = a | ~b;
      op_xnor:                     r = a ~^ b;
      op_min:                      r = ($signed(a) < $signed(b)) ? a : b;
      op_minu:                     r = (a < b) ? a : b;
      op_max:                      r = ($signed(a) > $signed(b)) ? a : b;
      op_maxu:                     r = (a > b) ? a : b;
      op_rol:                      r = (a << s) | (a >> (32 - s));
      op_ror, op_rori:             r = (a >> s) | (a << (32 - s));
      op_zexth:                    r = {16'b0, a[15:0]};
      op_clz: begin
        while (n < 32 && !t[31]) begin
          t = t << 1;
          n++;
        end
        r = n;
      end
      op_ctz: begin
        while (n < 32 && !t[0]) begin
          t = t >> 1;
          n++;
        end
        r = n;
      end
      op_cpop:                     r = $countones(a);
      op_sextb:                    r = {{24{a[7]}}, a[7:0]};
      op_sexth:                    r = {{16{a[15]}}, a[15:0]};
      op_rev8:                     r = {a[7:0], a[15:8], a[23:16], a[31:24]};
      op_orcb: begin
        for (int j = 0; j < 4; j++) begin
          r[8*j +: 8] = (a[8*j +: 8] != 8'h00) ? 8'hff : 8'h00;
        end
      end
      op_bclr, op_bclri:           r = a & ~(32'h1 << s);
      op_bset, op_bseti:           r = a | (32'h1 << s);
      op_binv, op_binvi:           r = a ^ (32'h1 << s);
      default:                     r = (a >> s) & 32'h1;
    endcase
    return r;
  endfunction

  function automatic logic [31:0] pick_value();
    case ($urandom_range(0, 3))
      0:       return 32'h0;
      1:       return 32'hffff_ffff << $urandom_range(0, 31);
      default: return $urandom;
    endcase
  endfunction

  // ************************************************************
  // Stimulus
  // ************************************************************

  task automatic issue(logic [31:0] word, logic wb, logic ill, logic [4:0] addr,
                       logic [31:0] data);
    @(posedge clk);
    instr_valid <= 1'b1;
    instr <= word;
    cfg_wr <= 1'b0;
    exp_wb_n <= wb;
    exp_ill_n <= ill;
    exp_addr_n <= addr;
    exp_data_n <= data;
    issued++;
  endtask

  task automatic idle();
    @(posedge clk);
    instr_valid <= 1'b0;
    cfg_wr <= 1'b0;
    exp_wb_n <= 1'b0;
    exp_ill_n <= 1'b0;
  endtask

  task automatic set_ext(logic [2:0] en);
    @(posedge clk);
    instr_valid <= 1'b0;
    cfg_wr <= 1'b1;
    cfg_data <= en;
    exp_wb_n <= 1'b0;
    exp_ill_n <= 1'b0;
    ext_model = en;  // Instructions from the next cycle see the new enables.
  endtask

  task automatic run_op(op_e op, logic [4:0] rd, logic [4:0] rs1, logic [4:0] rs2,
                        logic [31:0] imm);
    logic [2:0]  need;
    logic [2:0]  fmt;
    logic [6:0]  f7;
    logic [2:0]  f3;
    logic [4:0]  fix;
    logic [31:0] word;
    logic [31:0] b;
    logic [31:0] res;
    {need, fmt, f7, f3, fix} = op_spec(op);
    b = 32'h0;
    case (fmt)
      fmt_r: begin
        word = {f7, rs2, rs1, f3, rd, 7'b0110011};
        b = shadow[rs2];
      end
      fmt_i: begin
        word = {imm[11:0], rs1, f3, rd, 7'b0010011};
        b = {{20{imm[11]}}, imm[11:0]};
      end
      fmt_sh: begin
        word = {f7, imm[4:0], rs1, f3, rd, 7'b0010011};
        b = {27'b0, imm[4:0]};
      end
      fmt_un:  word = {f7, fix, rs1, f3, rd, 7'b0010011};
      fmt_ur:  word = {f7, fix, rs1, f3, rd, 7'b0110011};
      default: begin
        word = {imm[31:12], rd, f7};
        b = {imm[31:12], 12'b0};
      end
    endcase
    if ((need & ~ext_model) != 3'b000) begin
      issue(word, 1'b0, 1'b1, 5'd0, 32'h0);
    end else begin
      res = compute(op, shadow[rs1], b);
      issue(word, rd != 5'd0, 1'b0, rd, res);
      if (rd != 5'd0) shadow[rd] = res;
    end
  endtask

  // lui then addi, with the upper part rounded for the sign of the low twelve bits.
  task automatic load_reg(logic [4:0] r, logic [31:0] v);
    run_op(op_lui, r, 5'd0, 5'd0, v + 32'h800);
    run_op(op_addi, r, r, 5'd0, v);
  endtask

  task automatic random_op(op_e op);
    logic [4:0] rs1;
    logic [4:0] rs2;
    rs1 = 5'($urandom_range(1, 31));
    rs2 = 5'($urandom_range(1, 31));
    load_reg(rs1, pick_value());
    load_reg(rs2, pick_value());
    run_op(op, 5'($urandom_range(0, 31)), rs1, rs2, $urandom);
  endtask

  // The encoding must be rejected and x3 must keep its value.
  task automatic expect_illegal(logic [31:0] word);
    issue(word, 1'b0, 1'b1, 5'd0, 32'h0);
    run_op(op_add, 5'd31, 5'd3, 5'd0, 32'h0);
  endtask

  task automatic report_mismatch(string name, logic [31:0] expected, logic [31:0] actual);
    errors++;
    $display("CHECK FAILED at %0t: %s expected %h, got %h", $time, name, expected, actual);
  endtask

  // ************************************************************
  // Checks, one cycle after each strobe
  // ************************************************************

  always @(posedge clk) begin
    if (rst) begin
      exp_wb_q <= 1'b0;
      exp_ill_q <= 1'b0;
    end else begin
      exp_wb_q <= exp_wb_n;
      exp_ill_q <= exp_ill_n;
      exp_addr_q <= exp_addr_n;
      exp_data_q <= exp_data_n;
    end
  end

  wb_valid_check: assert property (@(posedge clk) disable iff (rst) wb_valid == exp_wb_q)
    else report_mismatch("wb_valid", 32'($sampled(exp_wb_q)), 32'($sampled(wb_valid)));
  illegal_check: assert property (@(posedge clk) disable iff (rst) illegal == exp_ill_q)
    else report_mismatch("illegal", 32'($sampled(exp_ill_q)), 32'($sampled(illegal)));
  wb_addr_check: assert property (@(posedge clk) disable iff (rst)
                                  exp_wb_q |-> wb_addr == exp_addr_q)
    else report_mismatch("wb_addr", 32'($sampled(exp_addr_q)), 32'($sampled(wb_addr)));
  wb_data_check: assert property (@(posedge clk) disable iff (rst)
                                  exp_wb_q |-> wb_data == exp_data_q)
    else report_mismatch("wb_data", $sampled(exp_data_q), $sampled(wb_data));

  initial begin
    while (cycle_count < timeout_cycles) begin
      @(posedge clk);
      cycle_count++;
    end
    $display("Timeout: the run did not finish within %0d cycles", timeout_cycles);
    $display("SIMULATION FAILED");
    $finish;
  end

  initial begin
    void'($urandom(60));
    rst = 1'b1;
    instr_valid = 1'b0;
    instr = 32'h0;
    cfg_wr = 1'b0;
    cfg_data = 3'b000;
    ext_model = 3'b111;
    for (int i = 0; i < 32; i++) begin
      shadow[i] = 32'h0;
    end
    repeat (10) @(posedge clk);
    rst <= 1'b0;

    for (int r = 0; r < rounds; r++) begin
      for (int k = 0; k < n_ops; k++) begin
        random_op(op_e'(k));
      end
    end

    run_op(op_addi, 5'd0, 5'd5, 5'd0, $urandom);  // Destination x0.
    run_op(op_add, 5'd6, 5'd0, 5'd0, 32'h0);

    for (int e = 0; e < 3; e++) begin
      set_ext(3'b111 & ~(3'b001 << e));
      for (int k = 0; k < n_ops; k++) begin
        random_op(op_e'(k));
      end
      set_ext(3'b111);
      for (int k = 0; k < n_ops; k++) begin
        random_op(op_e'(k));
      end
    end

    load_reg(5'd3, pick_value());
    expect_illegal({12'h000, 5'd1, 3'b010, 5'd3, 7'b0000011});          // lw
    expect_illegal({7'h00, 5'd2, 5'd1, 3'b010, 5'd3, 7'b0100011});      // sw
    expect_illegal({7'h00, 5'd2, 5'd1, 3'b000, 5'd3, 7'b1100011});      // beq
    expect_illegal({20'h00010, 5'd3, 7'b1101111});                      // jal
    expect_illegal(32'h0000_0073);                                      // ecall
    expect_illegal({7'h01, 5'd2, 5'd1, 3'b000, 5'd3, 7'b0110011});      // mul
    expect_illegal({7'h05, 5'd2, 5'd1, 3'b001, 5'd3, 7'b0110011});      // clmul
    expect_illegal({7'h7f, 5'd1, 5'd1, 3'b001, 5'd3, 7'b0010011});
    expect_illegal({17'h00000, 3'b000, 5'd3, 7'b1111111});

    load_reg(5'd7, pick_value());
    load_reg(5'd8, pick_value());
    repeat (40) begin
      run_op(op_e'($urandom_range(0, n_ops - 1)), 5'd7, 5'd7, 5'd8, $urandom);
    end

    idle();
    repeat (3) @(posedge clk);
    $display("Issued %0d instructions, %0d checks failed", issued, errors);
    if (errors == 0) begin
      $display("SIMULATION PASSED");
    end else begin
      $display("SIMULATION FAILED");
    end
    $finish;
  end

endmodule

`default_nettype wire

/* hdl/rv_exec_top.sv */
`timescale 1ns/1ps
`default_nettype none

module rv_exec_top import rv_pkg::*; (
  input  logic      clk,
  input  logic      rst,
  input  logic      instr_valid,
  input  instr_t    instr,
  input  logic      cfg_wr,
  input  ext_en_t   cfg_data,
  output logic      wb_valid,
  output reg_addr_t wb_addr,
  output word_t     wb_data,
  output logic      illegal
);

  ext_en_t   ext_en;
  reg_addr_t rs1_addr;
  reg_addr_t rs2_addr;
  reg_addr_t rd_addr;
  logic      rd_wren;
  word_t     imm;
  logic      use_imm;
  alu_op_t   alu_op;
  logic      legal;
  word_t     rs1_data;
  word_t     rs2_data;
  word_t     operand_b;
  word_t     alu_result;
  logic      wr_en;

  ext_cfg ext_cfg_i (
    .clk      (clk),
    .rst      (rst),
    .cfg_wr   (cfg_wr),
    .cfg_data (cfg_data),
    .ext_en   (ext_en)
  );

  decoder decoder_i (
    .instr    (instr),
    .ext_en   (ext_en),
    .rs1_addr (rs1_addr),
    .rs2_addr (rs2_addr),
    .rd_addr  (rd_addr),
    .rd_wren  (rd_wren),
    .imm      (imm),
    .use_imm  (use_imm),
    .alu_op   (alu_op),
    .legal    (legal)
  );

  regfile regfile_i (
    .clk      (clk),
    .rst      (rst),
    .rs1_addr (rs1_addr),
    .rs2_addr (rs2_addr),
    .rd_addr  (rd_addr),
    .rd_wren  (wr_en),
    .rd_data  (alu_result),
    .rs1_data (rs1_data),
    .rs2_data (rs2_data)
  );

  alu alu_i (
    .alu_op (alu_op),
    .a      (rs1_data),
    .b      (operand_b),
    .result (alu_result)
  );

  assign operand_b = use_imm ? imm : rs2_data;
  assign wr_en     = instr_valid && legal && rd_wren;  // Same term feeds the register file.

  // ************************************************************
  // Write-back and illegal strobes
  // ************************************************************

  always_ff @(posedge clk) begin
    if (rst) begin
      wb_valid <= 1'b0;
      illegal  <= 1'b0;
    end else begin
      wb_valid <= wr_en;
      illegal  <= instr_valid && !legal;
    end
  end

  always_ff @(posedge clk) begin
    wb_addr <= rd_addr;
    wb_data <= alu_result;  // Only meaningful while wb_valid is high.
  end

endmodule

`default_nettype wire

/* alu/alu.sv */
`timescale 1ns/1ps
`default_nettype none

`include "rv_macros.svh"

module alu import rv_pkg::*; (
  input  alu_op_t alu_op,
  input  word_t   a,
  input  word_t   b,
  output word_t   result
);

  localparam int SH_W  = $clog2(`XLEN);
  localparam int CNT_W = $clog2(`XLEN) + 1;

  logic [SH_W-1:0]    sh;
  word_t              bit_mask;
  logic [2*`XLEN-1:0] rol_full;
  logic [2*`XLEN-1:0] ror_full;
  logic               lt_s;
  logic               lt_u;
  logic [CNT_W-1:0]   clz_cnt;
  logic [CNT_W-1:0]   ctz_cnt;
  logic [CNT_W-1:0]   pop_cnt;
  logic               seen_hi;
  logic               seen_lo;
  word_t              rev8_res;
  word_t              orcb_res;

  assign sh       = b[SH_W-1:0];             // Shift amount and bit index.
  assign bit_mask = word_t'(1) << sh;
  assign rol_full = {a, a} << sh;            // Upper half holds the rotated word.
  assign ror_full = {a, a} >> sh;            // Lower half holds the rotated word.
  assign lt_s     = $signed(a) < $signed(b);
  assign lt_u     = a < b;

  // ************************************************************
  // Bit counts
  // ************************************************************

  always_comb begin
    clz_cnt = '0;
    ctz_cnt = '0;
    pop_cnt = '0;
    seen_hi = 1'b0;
    seen_lo = 1'b0;
    for (int i = 0; i < `XLEN; i++) begin
      if (a[`XLEN-1-i]) begin
        seen_hi = 1'b1;
      end else if (!seen_hi) begin
        clz_cnt = clz_cnt + 1'b1;
      end
      if (a[i]) begin
        seen_lo = 1'b1;
      end else if (!seen_lo) begin
        ctz_cnt = ctz_cnt + 1'b1;
      end
      pop_cnt = pop_cnt + CNT_W'(a[i]);
    end
  end

  // Byte reverse and byte OR-combine.
  always_comb begin
    for (int k = 0; k < `XLEN/8; k++) begin
      rev8_res[8*k +: 8] = a[`XLEN-8-8*k +: 8];
      orcb_res[8*k +: 8] = {8{|a[8*k +: 8]}};
    end
  end

  // ************************************************************
  // Result select
  // ************************************************************

  always_comb begin
    case (alu_op)
      alu_add:    result = a + b;
      alu_sub:    result = a - b;
      alu_sll:    result = a << sh;
      alu_srl:    result = a >> sh;
      alu_sra:    result = word_t'($signed(a) >>> sh);
      alu_slt:    result = word_t'(lt_s);
      alu_sltu:   result = word_t'(lt_u);
      alu_xor:    result = a ^ b;
      alu_or:     result = a | b;
      alu_and:    result = a & b;
      alu_pass:   result = b;
      alu_sh1add: result = (a << 1) + b;
      alu_sh2add: result = (a << 2) + b;
      alu_sh3add: result = (a << 3) + b;
      alu_andn:   result = a & ~b;
      alu_orn:    result = a | ~b;
      alu_xnor:   result = ~(a ^ b);
      alu_min:    result = lt_s ? a : b;
      alu_minu:   result = lt_u ? a : b;
      alu_max:    result = lt_s ? b : a;
      alu_maxu:   result = lt_u ? b : a;
      alu_clz:    result = word_t'(clz_cnt);
      alu_ctz:    result = word_t'(ctz_cnt);
      alu_cpop:   result = word_t'(pop_cnt);
      alu_sextb:  result = {{(`XLEN-8){a[7]}}, a[7:0]};
      alu_sexth:  result = {{(`XLEN-16){a[15]}}, a[15:0]};
      alu_zexth:  result = {{(`XLEN-16){1'b0}}, a[15:0]};
      alu_rev8:   result = rev8_res;
      alu_orcb:   result = orcb_res;
      alu_rol:    result = rol_full[2*`XLEN-1 -: `XLEN];
      alu_ror:    result = ror_full[`XLEN-1:0];
      alu_bclr:   result = a & ~bit_mask;
      alu_bset:   result = a | bit_mask;
      alu_binv:   result = a ^ bit_mask;
      alu_bext:   result = word_t'(a[sh]);
      default:    result = '0;
    endcase
  end

endmodule

`default_nettype wire

/* hdl/regfile.sv */
`timescale 1ns/1ps
`default_nettype none

`include "rv_macros.svh"

module regfile import rv_pkg::*; (
  input  logic      clk,
  input  logic      rst,
  input  reg_addr_t rs1_addr,
  input  reg_addr_t rs2_addr,
  input  reg_addr_t rd_addr,
  input  logic      rd_wren,
  input  word_t     rd_data,
  output word_t     rs1_data,
  output word_t     rs2_data
);

  word_t regs [1:`REG_COUNT-1];  // x0 has no storage.

  // ************************************************************
  // Write port
  // ************************************************************

  always_ff @(posedge clk) begin
    if (rst) begin
      for (int i = 1; i < `REG_COUNT; i++) begin
        regs[i] <= '0;
      end
    end else if (rd_wren && rd_addr != '0) begin
      regs[rd_addr] <= rd_data;
    end
  end

  // Read ports are combinational, so a write is seen the cycle after it.
  assign rs1_data = (rs1_addr == '0) ? '0 : regs[rs1_addr];
  assign rs2_data = (rs2_addr == '0) ? '0 : regs[rs2_addr];

endmodule

`default_nettype wire

/* decoder/decoder.sv */
`timescale 1ns/1ps
`default_nettype none

`include "rv_macros.svh"

module decoder import rv_pkg::*; (
  input  instr_t    instr,
  input  ext_en_t   ext_en,
  output reg_addr_t rs1_addr,
  output reg_addr_t rs2_addr,
  output reg_addr_t rd_addr,
  output logic      rd_wren,
  output word_t     imm,
  output logic      use_imm,
  output alu_op_t   alu_op,
  output logic      legal
);

  logic [6:0] opcode;
  logic [2:0] funct3;
  logic [4:0] funct5;
  logic [6:0] funct7;
  word_t      imm_i;
  word_t      imm_u;
  word_t      imm_sh;
  logic       known;  // Encoding belongs to the supported set.
  ext_en_t    need;   // Subset the encoding comes from.

  assign opcode = instr[6:0];
  assign funct3 = instr[14:12];
  assign funct5 = instr[24:20];
  assign funct7 = instr[31:25];

  assign rd_addr  = instr[11:7];
  assign rs1_addr = instr[19:15];
  assign rs2_addr = instr[24:20];

  assign imm_i  = {{(`XLEN-12){instr[31]}}, instr[31:20]};
  assign imm_u  = {instr[31:12], 12'h000};  // auipc sees a PC of zero.
  assign imm_sh = {{(`XLEN-5){1'b0}}, instr[24:20]};

  // ************************************************************
  // Encoding to ALU operation
  // ************************************************************

  always_comb begin
    known   = 1'b1;
    imm     = '0;
    use_imm = 1'b0;
    alu_op  = alu_add;
    case (opcode)
      `OPC_LUI, `OPC_AUIPC: begin
        imm     = imm_u;
        use_imm = 1'b1;
        alu_op  = alu_pass;
      end
      `OPC_OP_IMM: begin
        imm     = imm_i;
        use_imm = 1'b1;
        case (funct3)
          3'b000: alu_op = alu_add;
          3'b010: alu_op = alu_slt;
          3'b011: alu_op = alu_sltu;
          3'b100: alu_op = alu_xor;
          3'b110: alu_op = alu_or;
          3'b111: alu_op = alu_and;
          3'b001: begin
            imm = imm_sh;
            if (funct7 == 7'b0000000) alu_op = alu_sll;
            else if (funct7 == 7'b0100100) alu_op = alu_bclr;
            else if (funct7 == 7'b0010100) alu_op = alu_bset;
            else if (funct7 == 7'b0110100) alu_op = alu_binv;
            else if (funct7 == 7'b0110000 && funct5 == 5'b00000) alu_op = alu_clz;
            else if (funct7 == 7'b0110000 && funct5 == 5'b00001) alu_op = alu_ctz;
            else if (funct7 == 7'b0110000 && funct5 == 5'b00010) alu_op = alu_cpop;
            else if (funct7 == 7'b0110000 && funct5 == 5'b00100) alu_op = alu_sextb;
            else if (funct7 == 7'b0110000 && funct5 == 5'b00101) alu_op = alu_sexth;
            else known = 1'b0;
          end
          3'b101: begin
            imm = imm_sh;
            if (funct7 == 7'b0000000) alu_op = alu_srl;
            else if (funct7 == 7'b0100000) alu_op = alu_sra;
            else if (funct7 == 7'b0100100) alu_op = alu_bext;
            else if (funct7 == 7'b0110000) alu_op = alu_ror;
            else if (funct7 == 7'b0010100 && funct5 == 5'b00111) alu_op = alu_orcb;
            else if (funct7 == 7'b0110100 && funct5 == 5'b11000) alu_op = alu_rev8;
            else known = 1'b0;
          end
        endcase
      end
      `OPC_OP: begin
        case ({funct7, funct3})
          {7'b0000000, 3'b000}: alu_op = alu_add;
          {7'b0000000, 3'b001}: alu_op = alu_sll;
          {7'b0000000, 3'b010}: alu_op = alu_slt;
          {7'b0000000, 3'b011}: alu_op = alu_sltu;
          {7'b0000000, 3'b100}: alu_op = alu_xor;
          {7'b0000000, 3'b101}: alu_op = alu_srl;
          {7'b0000000, 3'b110}: alu_op = alu_or;
          {7'b0000000, 3'b111}: alu_op = alu_and;
          {7'b0100000, 3'b000}: alu_op = alu_sub;
          {7'b0100000, 3'b101}: alu_op = alu_sra;
          {7'b0100000, 3'b100}: alu_op = alu_xnor;
          {7'b0100000, 3'b110}: alu_op = alu_orn;
          {7'b0100000, 3'b111}: alu_op = alu_andn;
          {7'b0010000, 3'b010}: alu_op = alu_sh1add;
          {7'b0010000, 3'b100}: alu_op = alu_sh2add;
          {7'b0010000, 3'b110}: alu_op = alu_sh3add;
          {7'b0000101, 3'b100}: alu_op = alu_min;
          {7'b0000101, 3'b101}: alu_op = alu_minu;
          {7'b0000101, 3'b110}: alu_op = alu_max;
          {7'b0000101, 3'b111}: alu_op = alu_maxu;
          {7'b0110000, 3'b001}: alu_op = alu_rol;
          {7'b0110000, 3'b101}: alu_op = alu_ror;
          {7'b0100100, 3'b001}: alu_op = alu_bclr;
          {7'b0100100, 3'b101}: alu_op = alu_bext;
          {7'b0010100, 3'b001}: alu_op = alu_bset;
          {7'b0110100, 3'b001}: alu_op = alu_binv;
          {7'b0000100, 3'b100}: begin
            alu_op = alu_zexth;
            known  = (funct5 == 5'b00000);
          end
          default: known = 1'b0;  // M and Zbc land here.
        endcase
      end
      default: known = 1'b0;
    endcase
  end

  // ************************************************************
  // Extension gating
  // ************************************************************

  always_comb begin
    need = '0;
    case (alu_op)
      alu_sh1add, alu_sh2add, alu_sh3add:
        need[`EXT_ZBA] = 1'b1;
      alu_andn, alu_orn, alu_xnor, alu_min, alu_minu, alu_max, alu_maxu,
      alu_clz, alu_ctz, alu_cpop, alu_sextb, alu_sexth, alu_zexth,
      alu_rev8, alu_orcb, alu_rol, alu_ror:
        need[`EXT_ZBB] = 1'b1;
      alu_bclr, alu_bset, alu_binv, alu_bext:
        need[`EXT_ZBS] = 1'b1;
      default:
        need = '0;
    endcase
  end

  assign legal   = known && ((need & ~ext_en) == '0);
  assign rd_wren = legal && (rd_addr != '0);  // Writes to x0 are dropped here.

endmodule

`default_nettype wire

/* hdl/ext_cfg.sv */
`timescale 1ns/1ps
`default_nettype none

module ext_cfg import rv_pkg::*; (
  input  logic    clk,
  input  logic    rst,
  input  logic    cfg_wr,
  input  ext_en_t cfg_data,
  output ext_en_t ext_en
);

  // ************************************************************
  // Extension enable register
  // ************************************************************

  ext_en_t en_q;

  always_ff @(posedge clk) begin
    if (rst) begin
      en_q <= '1;  // Every subset is on after reset.
    end else if (cfg_wr) begin
      en_q <= cfg_data;
    end
  end

  assign ext_en = en_q;  // New value steers the decoder from the next cycle.

endmodule

`default_nettype wire

/* common/rv_pkg.sv */
`default_nettype none

`include "rv_macros.svh"

package rv_pkg;

  // ************************************************************
  // Word and field types
  // ************************************************************

  typedef logic [`XLEN-1:0]               word_t;
  typedef logic [$clog2(`REG_COUNT)-1:0]  reg_addr_t;
  typedef logic [`ILEN-1:0]               instr_t;
  typedef logic [`EXT_COUNT-1:0]          ext_en_t;  // One bit per bit-manipulation subset.

  // ************************************************************
  // ALU operation select
  // ************************************************************

  typedef enum logic [5:0] {
    // RV32I base operations.
    alu_add, alu_sub,
    alu_sll, alu_srl, alu_sra,
    alu_slt, alu_sltu,
    alu_xor, alu_or, alu_and,
    alu_pass,                         // Result is operand b, used by lui and auipc.
    // Zba.
    alu_sh1add, alu_sh2add, alu_sh3add,
    // Zbb logic and compare.
    alu_andn, alu_orn, alu_xnor,
    alu_min, alu_minu, alu_max, alu_maxu,
    // Zbb unary operations.
    alu_clz, alu_ctz, alu_cpop,
    alu_sextb, alu_sexth, alu_zexth,
    alu_rev8, alu_orcb,
    // Zbb rotates.
    alu_rol, alu_ror,
    // Zbs single bit operations.
    alu_bclr, alu_bset, alu_binv, alu_bext
  } alu_op_t;

endpackage

`default_nettype wire

/* common/rv_macros.svh */
`ifndef RV_MACROS_SVH
`define RV_MACROS_SVH

// Data path and register file sizes.
`define XLEN      32
`define ILEN      32
`define REG_COUNT 32

// Major opcodes of the instructions this slice executes.
`define OPC_OP     7'b0110011
`define OPC_OP_IMM 7'b0010011
`define OPC_LUI    7'b0110111
`define OPC_AUIPC  7'b0010111

// Bit positions in the extension enable vector.
`define EXT_ZBA   0
`define EXT_ZBB   1
`define EXT_ZBS   2
`define EXT_COUNT 3

`endif
